//--- hdl/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Data path widths
`define CACHE_XLEN 32
`define CACHE_LINE_W 128

// 16 sets
`define CACHE_INDEX_W 4

// Words per refill or writeback burst
`define CACHE_BEATS 4

// Backing memory, 4 KiB of words
`define CACHE_MEM_WORDS 1024
`define CACHE_MEM_LAT 3

`endif

//--- hdl/cache_pkg.sv
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

  typedef logic [`CACHE_XLEN-1:0] word_t;
  typedef logic [`CACHE_XLEN-1:0] addr_t;
  typedef logic [`CACHE_XLEN/8-1:0] strb_t;
  typedef logic [`CACHE_LINE_W-1:0] line_t;
  typedef logic [`CACHE_INDEX_W-1:0] index_t;

  // Whatever is left above index and line offset
  typedef logic [`CACHE_XLEN-`CACHE_INDEX_W-$clog2(`CACHE_LINE_W/8)-1:0] tag_t;

  typedef logic [$clog2(`CACHE_BEATS)-1:0] beat_t;

  typedef enum logic [2:0] {
    IDLE,
    WB_ADDR,
    WB_DATA,
    WB_RESP,
    RF_ADDR,
    RF_DATA
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/line_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module line_store
  import cache_pkg::*;
(
  input  wire         clk,
  input  wire         nrst,
  input  wire addr_t  i_addr,
  input  wire         i_wr_en,
  input  wire word_t  i_wdata,
  input  wire strb_t  i_wen,
  input  wire         i_fill_en,
  input  wire line_t  i_fill_line,
  output logic        o_hit,
  output logic        o_dirty,
  output tag_t        o_victim_tag,
  output line_t       o_line
);

  localparam int OFF_W = $clog2(`CACHE_LINE_W / 8);
  localparam int BYTE_W = $clog2(`CACHE_XLEN / 8);
  localparam int SETS = 1 << `CACHE_INDEX_W;

  tag_t tag_mem [SETS];
  line_t data_mem [SETS];
  logic [SETS-1:0] valid_q;
  logic [SETS-1:0] dirty_q;

  index_t idx;
  tag_t tag;
  beat_t word_sel;
  line_t stored;
  line_t merged;

  assign idx = i_addr[OFF_W +: `CACHE_INDEX_W];
  assign tag = i_addr[`CACHE_XLEN-1:OFF_W+`CACHE_INDEX_W];
  assign word_sel = i_addr[BYTE_W +: $bits(beat_t)];

  assign stored = data_mem[idx];
  assign o_hit = valid_q[idx] && (tag_mem[idx] == tag);
  assign o_dirty = valid_q[idx] && dirty_q[idx];
  assign o_victim_tag = tag_mem[idx];

  // Enabled bytes land in the addressed word only
  always_comb begin
    merged = stored;
    for (int b = 0; b < `CACHE_XLEN / 8; b++) begin
      if (i_wen[b]) begin
        merged[int'(word_sel) * `CACHE_XLEN + b * 8 +: 8] = i_wdata[b*8 +: 8];
      end
    end
  end

  assign o_line = i_wr_en ? merged : stored;

  always_ff @(posedge clk) begin
    if (i_fill_en) begin
      data_mem[idx] <= i_fill_line;
      tag_mem[idx] <= tag;
    end else if (i_wr_en && o_hit) begin
      data_mem[idx] <= merged;
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (i_fill_en) begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= 1'b0;
    end else if (i_wr_en && o_hit) begin
      dirty_q[idx] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_ctrl
  import cache_pkg::*;
(
  input  wire         clk,
  input  wire         nrst,
  // Requester side
  input  wire         i_valid,
  input  wire addr_t  i_addr,
  input  wire word_t  i_wdata,
  input  wire strb_t  i_wen,
  output logic        o_ready,
  output logic        o_valid,
  output addr_t       o_addr,
  output line_t       o_line,
  // Line store
  output addr_t       o_ls_addr,
  output logic        o_ls_wr_en,
  output word_t       o_ls_wdata,
  output strb_t       o_ls_wen,
  output logic        o_ls_fill_en,
  output line_t       o_ls_fill_line,
  input  wire         i_ls_hit,
  input  wire         i_ls_dirty,
  input  wire tag_t   i_ls_victim_tag,
  input  wire line_t  i_ls_line,
  // Memory side
  output logic        o_awvalid,
  output addr_t       o_awaddr,
  input  wire         i_awready,
  output logic        o_wvalid,
  output word_t       o_wdata,
  output logic        o_wlast,
  input  wire         i_wready,
  input  wire         i_bvalid,
  output logic        o_bready,
  output logic        o_arvalid,
  output addr_t       o_araddr,
  input  wire         i_arready,
  input  wire         i_rvalid,
  input  wire word_t  i_rdata,
  input  wire         i_rlast,
  output logic        o_rready
);

  localparam int OFF_W = $clog2(`CACHE_LINE_W / 8);
  localparam beat_t LAST_BEAT = beat_t'(`CACHE_BEATS - 1);

  ctrl_state_t state;
  logic pend;
  addr_t req_addr;
  word_t req_wdata;
  strb_t req_wen;
  beat_t wb_beat;
  word_t wb_word;
  logic [`CACHE_LINE_W-`CACHE_XLEN-1:0] rf_buf;
  logic accept;
  logic look_vld;

  // Held request blocks new ones until it is replayed
  assign o_ready = (state == IDLE) && !pend;
  assign accept = i_valid && o_ready;
  assign look_vld = (state == IDLE) && (pend || i_valid);

  assign o_ls_addr = pend ? req_addr : i_addr;
  assign o_ls_wdata = pend ? req_wdata : i_wdata;
  assign o_ls_wen = pend ? req_wen : i_wen;
  assign o_ls_wr_en = look_vld && i_ls_hit && (|o_ls_wen);
  assign o_ls_fill_en = (state == RF_DATA) && i_rvalid && i_rlast;
  assign o_ls_fill_line = {i_rdata, rf_buf};

  // Victim word for the current writeback beat
  always_comb begin
    wb_word = '0;
    for (int b = 0; b < `CACHE_BEATS; b++) begin
      if (wb_beat == beat_t'(b)) begin
        wb_word = i_ls_line[b*`CACHE_XLEN +: `CACHE_XLEN];
      end
    end
  end

  assign o_awvalid = (state == WB_ADDR);
  assign o_awaddr = {i_ls_victim_tag, req_addr[OFF_W +: `CACHE_INDEX_W], {OFF_W{1'b0}}};
  assign o_wvalid = (state == WB_DATA);
  assign o_wdata = wb_word;
  assign o_wlast = (wb_beat == LAST_BEAT);
  assign o_bready = (state == WB_RESP);
  assign o_arvalid = (state == RF_ADDR);
  assign o_araddr = {req_addr[`CACHE_XLEN-1:OFF_W], {OFF_W{1'b0}}};
  assign o_rready = (state == RF_DATA);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state <= IDLE;
      pend <= 1'b0;
      wb_beat <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= look_vld && i_ls_hit;
      case (state)
        IDLE: begin
          if (look_vld) begin
            if (i_ls_hit) begin
              pend <= 1'b0;
            end else begin
              pend <= 1'b1;
              state <= i_ls_dirty ? WB_ADDR : RF_ADDR;
            end
          end
        end
        WB_ADDR: begin
          if (i_awready) begin
            wb_beat <= '0;
            state <= WB_DATA;
          end
        end
        WB_DATA: begin
          if (i_wready) begin
            wb_beat <= wb_beat + 1'b1;
            if (o_wlast) begin
              state <= WB_RESP;
            end
          end
        end
        WB_RESP: begin
          if (i_bvalid) begin
            state <= RF_ADDR;
          end
        end
        RF_ADDR: begin
          if (i_arready) begin
            state <= RF_DATA;
          end
        end
        RF_DATA: begin
          // Back to IDLE to replay, the line is now present
          if (i_rvalid && i_rlast) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !i_ls_hit) begin
      req_addr <= i_addr;
      req_wdata <= i_wdata;
      req_wen <= i_wen;
    end
    // Refill beats arrive lowest word first
    if (state == RF_DATA && i_rvalid) begin
      rf_buf <= {i_rdata, rf_buf[`CACHE_LINE_W-`CACHE_XLEN-1:`CACHE_XLEN]};
    end
    if (look_vld && i_ls_hit) begin
      o_addr <= o_ls_addr;
      o_line <= i_ls_line;
    end
  end

  // Address requests hold until the memory takes them
  a_aw_hold: assert property (@(posedge clk) disable iff (!nrst)
    o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr));

  a_ar_hold: assert property (@(posedge clk) disable iff (!nrst)
    o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));

  // A held request must hit once its line is refilled
  a_replay_hit: assert property (@(posedge clk) disable iff (!nrst)
    state == IDLE && pend |-> i_ls_hit);

endmodule

`default_nettype wire

//--- hdl/burst_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module burst_mem
  import cache_pkg::*;
(
  input  wire         clk,
  input  wire         nrst,
  input  wire         i_awvalid,
  input  wire addr_t  i_awaddr,
  output logic        o_awready,
  input  wire         i_wvalid,
  input  wire word_t  i_wdata,
  input  wire         i_wlast,
  output logic        o_wready,
  output logic        o_bvalid,
  input  wire         i_bready,
  input  wire         i_arvalid,
  input  wire addr_t  i_araddr,
  output logic        o_arready,
  output logic        o_rvalid,
  output word_t       o_rdata,
  output logic        o_rlast,
  input  wire         i_rready
);

  localparam int WADDR_W = $clog2(`CACHE_MEM_WORDS);
  localparam int BYTE_W = $clog2(`CACHE_XLEN / 8);
  localparam int LAT_W = $clog2(`CACHE_MEM_LAT + 1);
  localparam beat_t LAST_BEAT = beat_t'(`CACHE_BEATS - 1);

  word_t mem [`CACHE_MEM_WORDS] = '{default: '0};

  logic w_busy;
  logic [WADDR_W-1:0] w_ptr;
  beat_t w_beat;
  logic r_busy;
  logic [WADDR_W-1:0] r_ptr;
  beat_t r_beat;
  logic [LAT_W-1:0] r_wait;

  // Write burst, new address only once the response is taken
  assign o_awready = !w_busy && !o_bvalid;
  assign o_wready = w_busy;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      w_busy <= 1'b0;
      w_beat <= '0;
      o_bvalid <= 1'b0;
    end else begin
      if (i_awvalid && o_awready) begin
        w_busy <= 1'b1;
        w_beat <= '0;
      end else if (i_wvalid && o_wready) begin
        w_beat <= w_beat + 1'b1;
        if (i_wlast) begin
          w_busy <= 1'b0;
          o_bvalid <= 1'b1;
        end
      end
      if (o_bvalid && i_bready) begin
        o_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_awvalid && o_awready) begin
      w_ptr <= i_awaddr[BYTE_W +: WADDR_W];
    end else if (i_wvalid && o_wready) begin
      w_ptr <= w_ptr + 1'b1;
    end
    if (i_wvalid && o_wready) begin
      mem[w_ptr] <= i_wdata;
    end
  end

  // Read burst after a fixed wait
  assign o_arready = !r_busy;
  assign o_rvalid = r_busy && (r_wait == '0);
  assign o_rdata = mem[r_ptr];
  assign o_rlast = (r_beat == LAST_BEAT);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      r_busy <= 1'b0;
      r_beat <= '0;
      r_wait <= '0;
    end else if (i_arvalid && o_arready) begin
      r_busy <= 1'b1;
      r_beat <= '0;
      r_wait <= LAT_W'(`CACHE_MEM_LAT);
    end else if (r_wait != '0) begin
      r_wait <= r_wait - 1'b1;
    end else if (o_rvalid && i_rready) begin
      r_beat <= r_beat + 1'b1;
      if (o_rlast) begin
        r_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_arvalid && o_arready) begin
      r_ptr <= i_araddr[BYTE_W +: WADDR_W];
    end else if (o_rvalid && i_rready) begin
      r_ptr <= r_ptr + 1'b1;
    end
  end

  a_wlast_beat: assert property (@(posedge clk) disable iff (!nrst)
    i_wvalid && o_wready && w_beat == LAST_BEAT |-> i_wlast);

endmodule

`default_nettype wire

//--- hdl/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_top
  import cache_pkg::*;
(
  input  wire         clk,
  input  wire         nrst,
  input  wire         i_valid,
  input  wire addr_t  i_addr,
  input  wire word_t  i_wdata,
  input  wire strb_t  i_wen,
  output logic        o_ready,
  output logic        o_valid,
  output addr_t       o_addr,
  output line_t       o_line
);

  // Controller to line store
  addr_t ls_addr;
  logic ls_wr_en;
  word_t ls_wdata;
  strb_t ls_wen;
  logic ls_fill_en;
  line_t ls_fill_line;
  logic ls_hit;
  logic ls_dirty;
  tag_t ls_victim_tag;
  line_t ls_line;

  // Memory channels
  logic awvalid;
  addr_t awaddr;
  logic awready;
  logic wvalid;
  word_t wdata;
  logic wlast;
  logic wready;
  logic bvalid;
  logic bready;
  logic arvalid;
  addr_t araddr;
  logic arready;
  logic rvalid;
  word_t rdata;
  logic rlast;
  logic rready;

  cache_ctrl cache_ctrl_inst (
    .clk             (clk),
    .nrst            (nrst),
    .i_valid         (i_valid),
    .i_addr          (i_addr),
    .i_wdata         (i_wdata),
    .i_wen           (i_wen),
    .o_ready         (o_ready),
    .o_valid         (o_valid),
    .o_addr          (o_addr),
    .o_line          (o_line),
    .o_ls_addr       (ls_addr),
    .o_ls_wr_en      (ls_wr_en),
    .o_ls_wdata      (ls_wdata),
    .o_ls_wen        (ls_wen),
    .o_ls_fill_en    (ls_fill_en),
    .o_ls_fill_line  (ls_fill_line),
    .i_ls_hit        (ls_hit),
    .i_ls_dirty      (ls_dirty),
    .i_ls_victim_tag (ls_victim_tag),
    .i_ls_line       (ls_line),
    .o_awvalid       (awvalid),
    .o_awaddr        (awaddr),
    .i_awready       (awready),
    .o_wvalid        (wvalid),
    .o_wdata         (wdata),
    .o_wlast         (wlast),
    .i_wready        (wready),
    .i_bvalid        (bvalid),
    .o_bready        (bready),
    .o_arvalid       (arvalid),
    .o_araddr        (araddr),
    .i_arready       (arready),
    .i_rvalid        (rvalid),
    .i_rdata         (rdata),
    .i_rlast         (rlast),
    .o_rready        (rready)
  );

  line_store line_store_inst (
    .clk          (clk),
    .nrst         (nrst),
    .i_addr       (ls_addr),
    .i_wr_en      (ls_wr_en),
    .i_wdata      (ls_wdata),
    .i_wen        (ls_wen),
    .i_fill_en    (ls_fill_en),
    .i_fill_line  (ls_fill_line),
    .o_hit        (ls_hit),
    .o_dirty      (ls_dirty),
    .o_victim_tag (ls_victim_tag),
    .o_line       (ls_line)
  );

  burst_mem burst_mem_inst (
    .clk       (clk),
    .nrst      (nrst),
    .i_awvalid (awvalid),
    .i_awaddr  (awaddr),
    .o_awready (awready),
    .i_wvalid  (wvalid),
    .i_wdata   (wdata),
    .i_wlast   (wlast),
    .o_wready  (wready),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .i_arvalid (arvalid),
    .i_araddr  (araddr),
    .o_arready (arready),
    .o_rvalid  (rvalid),
    .o_rdata   (rdata),
    .o_rlast   (rlast),
    .i_rready  (rready)
  );

endmodule

`default_nettype wire

//--- verif/cache_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_checker
  import cache_pkg::*;
(
  input  wire         clk,
  input  wire         nrst,
  input  wire         i_valid,
  input  wire addr_t  i_addr,
  input  wire word_t  i_wdata,
  input  wire strb_t  i_wen,
  input  wire         i_ready,
  input  wire         i_done,
  input  wire addr_t  i_done_addr,
  input  wire line_t  i_done_line,
  input  wire         i_report,
  output int          o_errors
);

  localparam int SETS = 1 << `CACHE_INDEX_W;

  logic [7:0] ref_mem [4096];
  tag_t ref_tag [SETS];
  logic [SETS-1:0] ref_vld;

  addr_t q_addr [$];
  line_t q_line [$];
  logic q_hit [$];
  int q_cyc [$];

  int cycle = 0;
  int err_cnt = 0;
  int done_cnt = 0;

  assign o_errors = err_cnt;

  initial begin
    for (int i = 0; i < 4096; i++) begin
      ref_mem[i] = 8'h00;
    end
  end

  function automatic line_t ref_line(input addr_t a);
    line_t l;
    logic [11:0] base;
    l = '0;
    base = {a[11:4], 4'h0};
    for (int k = 0; k < 16; k++) begin
      l[k*8 +: 8] = ref_mem[base + 12'(k)];
    end
    return l;
  endfunction

  task automatic record_request();
    index_t idx;
    tag_t tg;
    logic hit;
    idx = i_addr[7:4];
    tg = i_addr[31:8];
    for (int b = 0; b < 4; b++) begin
      if (i_wen[b]) begin
        ref_mem[{i_addr[11:2], 2'(b)}] = i_wdata[b*8 +: 8];
      end
    end
    // Direct mapped, so the resident tag decides hit or miss
    hit = ref_vld[idx] && (ref_tag[idx] == tg);
    ref_vld[idx] = 1'b1;
    ref_tag[idx] = tg;
    q_addr.push_back(i_addr);
    q_line.push_back(ref_line(i_addr));
    q_hit.push_back(hit);
    q_cyc.push_back(cycle);
  endtask

  task automatic check_completion();
    addr_t ea;
    line_t el;
    logic eh;
    int ec;
    logic ok;
    if (q_addr.size() == 0) begin
      $display("extra completion at %0t with no request outstanding", $time);
      err_cnt++;
      return;
    end
    ea = q_addr.pop_front();
    el = q_line.pop_front();
    eh = q_hit.pop_front();
    ec = q_cyc.pop_front();
    done_cnt++;
    ok = 1'b1;
    if (i_done_addr !== ea) begin
      $display("error at %0t: access %0d returned address %h, expected %h",
               $time, done_cnt, i_done_addr, ea);
      ok = 1'b0;
    end
    if (i_done_line !== el) begin
      $display("error at %0t: access %0d line %h, expected %h",
               $time, done_cnt, i_done_line, el);
      ok = 1'b0;
    end
    if (eh && (cycle - ec != 1 || !i_ready)) begin
      $display("error at %0t: hit access %0d took %0d cycles, ready %b",
               $time, done_cnt, cycle - ec, i_ready);
      ok = 1'b0;
    end
    if (ok) begin
      $display("access %0d ok: addr %h %s line %h", done_cnt, ea, eh ? "hit " : "miss", el);
    end else begin
      err_cnt++;
    end
  endtask

  always @(posedge clk) begin
    cycle++;
    if (!nrst) begin
      ref_vld = '0;
    end else begin
      // Completion first, it belongs to an earlier request
      if (i_done) begin
        check_completion();
      end
      if (i_valid && i_ready) begin
        record_request();
      end
    end
  end

  always @(posedge nrst) begin
    @(negedge clk);
    if (i_done !== 1'b0 || i_ready !== 1'b1) begin
      $display("error at %0t: after reset valid %b ready %b", $time, i_done, i_ready);
      err_cnt++;
    end
  end

  always @(posedge i_report) begin
    if (q_addr.size() != 0) begin
      $display("%0d accepted requests never completed", q_addr.size());
      err_cnt += q_addr.size();
    end
    $display("summary: %0d accesses checked, %0d errors", done_cnt, err_cnt);
  end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tb_top
  import cache_pkg::*;
();

  localparam int MAX_CASES = 64;
  localparam int RAND_COUNT = 40;
  localparam int CYCLES_PER_ACCESS = 40;
  localparam int CLK_PERIOD = 10;

  integer seed = 80198;

  logic clk = 1'b0;
  logic nrst;
  logic i_valid;
  addr_t i_addr;
  word_t i_wdata;
  strb_t i_wen;
  logic o_ready;
  logic o_valid;
  addr_t o_addr;
  line_t o_line;

  logic report_req;
  int errors;

  addr_t case_addr [MAX_CASES];
  word_t case_wdata [MAX_CASES];
  strb_t case_wen [MAX_CASES];
  int n_cases;
  logic loaded = 1'b0;

  // Six distinct lines in sets 5 and 9, two of them weighted twice
  addr_t hot_lines [8] = '{32'h050, 32'h150, 32'h250, 32'h090,
                           32'h190, 32'h290, 32'h050, 32'h190};

  always #(CLK_PERIOD / 2) clk = ~clk;

  cache_top cache_top_inst (
    .clk     (clk),
    .nrst    (nrst),
    .i_valid (i_valid),
    .i_addr  (i_addr),
    .i_wdata (i_wdata),
    .i_wen   (i_wen),
    .o_ready (o_ready),
    .o_valid (o_valid),
    .o_addr  (o_addr),
    .o_line  (o_line)
  );

  cache_checker cache_checker_inst (
    .clk          (clk),
    .nrst         (nrst),
    .i_valid      (i_valid),
    .i_addr       (i_addr),
    .i_wdata      (i_wdata),
    .i_wen        (i_wen),
    .i_ready      (o_ready),
    .i_done       (o_valid),
    .i_done_addr  (o_addr),
    .i_done_line  (o_line),
    .i_report     (report_req),
    .o_errors     (errors)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic load_cases();
    int fd;
    int n;
    string text;
    byte op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    n_cases = 0;
    fd = $fopen("verif/cache_cases.txt", "r");
    if (fd == 0) begin
      n_cases = -1;
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(text, fd) == 0) begin
        break;
      end
      if (text.len() == 0 || text[0] == "#") begin
        continue;
      end
      n = $sscanf(text, "%c %h %h %h", op, a, d, e);
      if (n == 4 && n_cases < MAX_CASES) begin
        case_addr[n_cases] = a;
        case_wdata[n_cases] = d;
        case_wen[n_cases] = (op == "W") ? e[3:0] : 4'h0;
        n_cases++;
      end
    end
    $fclose(fd);
  endtask

  // Called on a falling edge, returns on the falling edge that shows o_valid
  task automatic run_access(input addr_t a, input word_t d, input strb_t e);
    while (!o_ready) begin
      @(negedge clk);
    end
    i_valid = 1'b1;
    i_addr = a;
    i_wdata = d;
    i_wen = e;
    @(posedge clk);
    @(negedge clk);
    i_valid = 1'b0;
    while (!o_valid) begin
      @(negedge clk);
    end
  endtask

  initial begin
    word_t r;
    word_t d;
    addr_t a;
    strb_t e;
    nrst = 1'b0;
    i_valid = 1'b0;
    i_addr = '0;
    i_wdata = '0;
    i_wen = '0;
    report_req = 1'b0;
    load_cases();
    if (n_cases < 0) begin
      abort_run("could not open verif/cache_cases.txt");
    end else begin
      loaded = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      nrst = 1'b1;
      @(negedge clk);
      for (int i = 0; i < n_cases; i++) begin
        run_access(case_addr[i], case_wdata[i], case_wen[i]);
      end
      for (int i = 0; i < RAND_COUNT; i++) begin
        r = $random(seed);
        d = $random(seed);
        a = hot_lines[r[2:0]] | addr_t'({r[4:3], 2'b00});
        e = r[8] ? r[12:9] : 4'h0;
        run_access(a, d, e);
      end
      i_valid = 1'b0;
      repeat (3) @(negedge clk);
      report_req = 1'b1;
      #1;
      if (errors == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

  // Watchdog sized from the number of accesses
  initial begin
    wait (loaded);
    #((n_cases + RAND_COUNT + 2) * CYCLES_PER_ACCESS * CLK_PERIOD);
    abort_run("timeout: the accesses did not all complete in time");
  end

endmodule

`default_nettype wire

//--- verif/cache_cases.txt
# op addr wdata wen, all hex; op R is a read, W a write
# expected lines come from the checker's reference memory
R 00000000 00000000 0
W 00000004 a1b2c3d4 3
R 00000004 00000000 0
W 00000008 11223344 f
W 0000000c 55667788 4
R 00000000 00000000 0
W 00000020 deadbeef f
R 00000120 00000000 0
R 00000220 00000000 0
R 00000020 00000000 0
W 00000124 cafef00d 9
W 00000228 01020304 f
R 00000128 00000000 0
R 00000224 00000000 0
R 00000024 00000000 0
W 000003f0 0badf00d 6
R 000007f0 00000000 0
R 00000bf0 00000000 0
R 000003f4 00000000 0
R 000003f0 00000000 0
W 00000f3c 89abcdef 8
R 00000f30 00000000 0

//--- tb.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/line_store.sv
hdl/cache_ctrl.sv
hdl/burst_mem.sv
hdl/cache_top.sv
verif/cache_checker.sv
verif/tb_top.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module tb_top -Mdir obj_dir

run: build
	./obj_dir/Vtb_top | tee /dev/stderr | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing -f tb.f --top-module tb_top
	verilator --lint-only -f tb.f --top-module cache_top

clean:
	rm -rf obj_dir
